//--- source/bp_pkg.sv
`default_nettype none

package bp_pkg;

    localparam int XLEN = 32;

    // gshare pattern table
    localparam int PHT_BITS = 8;
    localparam int PHT_SIZE = 1 << PHT_BITS;

    // direct mapped btb, index from pc[7:2]
    localparam int BTB_BITS = 6;
    localparam int BTB_SIZE = 1 << BTB_BITS;

    localparam int RAS_DEPTH = 8;

    typedef logic [XLEN-1:0]            addr_t;
    typedef logic [PHT_BITS-1:0]        ghist_t;   // also the pht index
    typedef logic [1:0]                 ctr_t;
    typedef logic [BTB_BITS-1:0]        btb_idx_t;
    typedef logic [XLEN-BTB_BITS-3:0]   btb_tag_t; // pc[31:8]
    typedef logic [$clog2(RAS_DEPTH)-1:0]   ras_ptr_t;
    typedef logic [$clog2(RAS_DEPTH+1)-1:0] ras_cnt_t;

    localparam ctr_t CTR_INIT = 2'd1;  // weakly not-taken
    localparam ctr_t CTR_MAX  = 2'd3;

    // fixed instruction size
    localparam addr_t PC_STEP = 32'd4;

    typedef enum logic [1:0] {
        KIND_BRANCH,
        KIND_JUMP,
        KIND_CALL,
        KIND_RET
    } br_kind_e;

endpackage

`default_nettype wire

//--- source/direction_predictor.sv
`timescale 1ns/1ps
`default_nettype none

module direction_predictor (
    input  wire logic             clk,
    input  wire logic             rstn,
    input  wire logic             lookup_en,
    input  wire bp_pkg::addr_t    lookup_pc,
    input  wire logic             upd_valid,
    input  wire bp_pkg::addr_t    upd_pc,
    input  wire bp_pkg::br_kind_e upd_kind,
    input  wire logic             upd_taken,
    output logic                  dir_taken
);
    import bp_pkg::*;

    ctr_t   pht [PHT_SIZE];
    ghist_t ghist;
    ctr_t   rd_ctr;

    ghist_t lkp_idx;
    ghist_t upd_idx;
    ctr_t   upd_ctr;
    logic   br_upd;

    assign lkp_idx = lookup_pc[PHT_BITS+1:2] ^ ghist;
    assign upd_idx = upd_pc[PHT_BITS+1:2] ^ ghist;
    assign upd_ctr = pht[upd_idx];
    assign br_upd  = upd_valid && (upd_kind == KIND_BRANCH);

    // counter training and history shift, commit only
    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int i = 0; i < PHT_SIZE; i++) begin
                pht[i] <= CTR_INIT;
            end
            ghist <= '0;
        end else if (br_upd) begin
            if (upd_taken) begin
                if (upd_ctr != CTR_MAX) begin
                    pht[upd_idx] <= upd_ctr + 2'd1;
                end
            end else if (upd_ctr != 2'd0) begin
                pht[upd_idx] <= upd_ctr - 2'd1;
            end
            ghist <= {ghist[PHT_BITS-2:0], upd_taken};
        end
    end

    // read data held between lookups
    always_ff @(posedge clk) begin
        if (lookup_en) begin
            rd_ctr <= pht[lkp_idx];  // old state on a same-cycle update
        end
    end

    assign dir_taken = rd_ctr[1];

    // only a committed conditional branch may move the history
    a_ghist_stable : assert property (
        @(posedge clk) disable iff (!rstn)
        !br_upd |=> $stable(ghist)
    ) else $error("global history changed without a branch update");

endmodule

`default_nettype wire

//--- source/target_predictor.sv
`timescale 1ns/1ps
`default_nettype none

module target_predictor (
    input  wire logic             clk,
    input  wire logic             rstn,
    input  wire logic             lookup_en,
    input  wire bp_pkg::addr_t    lookup_pc,
    input  wire logic             upd_valid,
    input  wire bp_pkg::addr_t    upd_pc,
    input  wire bp_pkg::br_kind_e upd_kind,
    input  wire logic             upd_taken,
    input  wire bp_pkg::addr_t    upd_target,
    output logic                  btb_hit,
    output bp_pkg::br_kind_e      btb_kind,
    output bp_pkg::addr_t         btb_target,
    output bp_pkg::addr_t         ras_top,
    output logic                  ras_empty
);
    import bp_pkg::*;

    // btb storage
    logic     btb_valid  [BTB_SIZE];
    btb_tag_t btb_tag    [BTB_SIZE];
    br_kind_e btb_kind_m [BTB_SIZE];
    addr_t    btb_tgt_m  [BTB_SIZE];

    // return stack, wr_ptr points at the next free slot
    addr_t    ras_mem [RAS_DEPTH];
    ras_ptr_t ras_wr_ptr;
    ras_ptr_t ras_top_ptr;
    ras_cnt_t ras_cnt;

    btb_idx_t lkp_idx;
    btb_tag_t lkp_tag;
    btb_idx_t upd_idx;
    logic     btb_wr;
    logic     ras_push;
    logic     ras_pop;

    assign lkp_idx = lookup_pc[BTB_BITS+1:2];
    assign lkp_tag = lookup_pc[XLEN-1:BTB_BITS+2];
    assign upd_idx = upd_pc[BTB_BITS+1:2];

    // not-taken branches never allocate
    assign btb_wr = upd_valid && (upd_taken || (upd_kind != KIND_BRANCH));

    assign ras_push    = upd_valid && (upd_kind == KIND_CALL);
    assign ras_pop     = upd_valid && (upd_kind == KIND_RET) && (ras_cnt != '0);
    assign ras_top_ptr = ras_wr_ptr - ras_ptr_t'(1);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int i = 0; i < BTB_SIZE; i++) begin
                btb_valid[i] <= 1'b0;
            end
        end else if (btb_wr) begin
            btb_valid[upd_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (btb_wr) begin
            btb_tag[upd_idx]    <= upd_pc[XLEN-1:BTB_BITS+2];
            btb_kind_m[upd_idx] <= upd_kind;
            btb_tgt_m[upd_idx]  <= upd_target;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            ras_wr_ptr <= '0;
            ras_cnt    <= '0;
        end else if (ras_push) begin
            ras_wr_ptr <= ras_wr_ptr + ras_ptr_t'(1);  // wraps over the oldest
            if (ras_cnt != ras_cnt_t'(RAS_DEPTH)) begin
                ras_cnt <= ras_cnt + ras_cnt_t'(1);
            end
        end else if (ras_pop) begin
            ras_wr_ptr <= ras_top_ptr;
            ras_cnt    <= ras_cnt - ras_cnt_t'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (ras_push) begin
            ras_mem[ras_wr_ptr] <= upd_pc + PC_STEP;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            btb_hit   <= 1'b0;
            ras_empty <= 1'b1;
        end else if (lookup_en) begin
            btb_hit   <= btb_valid[lkp_idx] && (btb_tag[lkp_idx] == lkp_tag);
            ras_empty <= (ras_cnt == '0);
        end
    end

    // payload side of the lookup
    always_ff @(posedge clk) begin
        if (lookup_en) begin
            btb_kind   <= btb_kind_m[lkp_idx];
            btb_target <= btb_tgt_m[lkp_idx];
            ras_top    <= ras_mem[ras_top_ptr];
        end
    end

    a_ras_cnt_max : assert property (
        @(posedge clk) disable iff (!rstn)
        ras_cnt <= ras_cnt_t'(RAS_DEPTH)
    ) else $error("return stack count above depth");

    // a return on an empty stack leaves it empty and in place
    a_ras_pop : assert property (
        @(posedge clk) disable iff (!rstn)
        (upd_valid && (upd_kind == KIND_RET) && (ras_cnt == '0)) |=>
            ((ras_cnt == '0) && $stable(ras_wr_ptr))
    ) else $error("return stack popped while empty");

endmodule

`default_nettype wire

//--- source/next_pc_select.sv
`timescale 1ns/1ps
`default_nettype none

module next_pc_select (
    input  wire logic             clk,
    input  wire logic             rstn,
    input  wire logic             pc_valid,
    input  wire bp_pkg::addr_t    pc,
    output logic                  pc_ready,
    output logic                  lookup_en,
    output bp_pkg::addr_t         lookup_pc,
    input  wire logic             dir_taken,
    input  wire logic             btb_hit,
    input  wire bp_pkg::br_kind_e btb_kind,
    input  wire bp_pkg::addr_t    btb_target,
    input  wire bp_pkg::addr_t    ras_top,
    input  wire logic             ras_empty,
    output logic                  pred_valid,
    output bp_pkg::addr_t         pred_pc,
    output bp_pkg::addr_t         pred_npc,
    output logic                  pred_taken,
    output bp_pkg::br_kind_e      pred_kind,
    output logic                  pred_hit,
    input  wire logic             pred_ready
);
    import bp_pkg::*;

    addr_t seq_pc;

    assign pc_ready  = !pred_valid || pred_ready;
    assign lookup_en = pc_valid && pc_ready;
    assign lookup_pc = pc;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            pred_valid <= 1'b0;
        end else if (lookup_en) begin
            pred_valid <= 1'b1;
        end else if (pred_ready) begin
            pred_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (lookup_en) begin
            pred_pc <= pc;
        end
    end

    assign seq_pc    = pred_pc + PC_STEP;
    assign pred_hit  = btb_hit;
    assign pred_kind = btb_hit ? btb_kind : KIND_BRANCH;  // don't care on a miss

    always_comb begin
        pred_taken = 1'b0;
        pred_npc   = seq_pc;
        if (btb_hit) begin
            case (btb_kind)
                KIND_JUMP, KIND_CALL: begin
                    pred_taken = 1'b1;
                    pred_npc   = btb_target;
                end
                KIND_RET: begin
                    if (!ras_empty) begin
                        pred_taken = 1'b1;
                        pred_npc   = ras_top;
                    end
                end
                default: begin  // conditional
                    if (dir_taken) begin
                        pred_taken = 1'b1;
                        pred_npc   = btb_target;
                    end
                end
            endcase
        end
    end

    // side outputs must hold while the registered pc is stalled
    a_pred_hold : assert property (
        @(posedge clk) disable iff (!rstn)
        (pred_valid && !pred_ready) |=>
            (pred_valid && $stable(pred_pc) && $stable(pred_npc) &&
             $stable(pred_taken) && $stable(pred_kind) && $stable(pred_hit))
    ) else $error("prediction changed under back-pressure");

endmodule

`default_nettype wire

//--- source/branch_predictor.sv
`timescale 1ns/1ps
`default_nettype none

module branch_predictor (
    input  wire logic             clk,
    input  wire logic             rstn,

    // lookup request
    input  wire logic             pc_valid,
    input  wire bp_pkg::addr_t    pc,
    output logic                  pc_ready,

    // prediction
    output logic                  pred_valid,
    output bp_pkg::addr_t         pred_pc,
    output bp_pkg::addr_t         pred_npc,
    output logic                  pred_taken,
    output bp_pkg::br_kind_e      pred_kind,
    output logic                  pred_hit,
    input  wire logic             pred_ready,

    // resolved branch from execute
    input  wire logic             upd_valid,
    input  wire bp_pkg::addr_t    upd_pc,
    input  wire bp_pkg::br_kind_e upd_kind,
    input  wire logic             upd_taken,
    input  wire bp_pkg::addr_t    upd_target
);
    import bp_pkg::*;

    logic     lookup_en;
    addr_t    lookup_pc;
    logic     dir_taken;
    logic     btb_hit;
    br_kind_e btb_kind;
    addr_t    btb_target;
    addr_t    ras_top;
    logic     ras_empty;

    direction_predictor u_dir (
        .clk       (clk),
        .rstn      (rstn),
        .lookup_en (lookup_en),
        .lookup_pc (lookup_pc),
        .upd_valid (upd_valid),
        .upd_pc    (upd_pc),
        .upd_kind  (upd_kind),
        .upd_taken (upd_taken),
        .dir_taken (dir_taken)
    );

    target_predictor u_tgt (
        .clk        (clk),
        .rstn       (rstn),
        .lookup_en  (lookup_en),
        .lookup_pc  (lookup_pc),
        .upd_valid  (upd_valid),
        .upd_pc     (upd_pc),
        .upd_kind   (upd_kind),
        .upd_taken  (upd_taken),
        .upd_target (upd_target),
        .btb_hit    (btb_hit),
        .btb_kind   (btb_kind),
        .btb_target (btb_target),
        .ras_top    (ras_top),
        .ras_empty  (ras_empty)
    );

    next_pc_select u_sel (
        .clk        (clk),
        .rstn       (rstn),
        .pc_valid   (pc_valid),
        .pc         (pc),
        .pc_ready   (pc_ready),
        .lookup_en  (lookup_en),
        .lookup_pc  (lookup_pc),
        .dir_taken  (dir_taken),
        .btb_hit    (btb_hit),
        .btb_kind   (btb_kind),
        .btb_target (btb_target),
        .ras_top    (ras_top),
        .ras_empty  (ras_empty),
        .pred_valid (pred_valid),
        .pred_pc    (pred_pc),
        .pred_npc   (pred_npc),
        .pred_taken (pred_taken),
        .pred_kind  (pred_kind),
        .pred_hit   (pred_hit),
        .pred_ready (pred_ready)
    );

endmodule

`default_nettype wire

//--- tb/tb_branch_predictor.sv
`timescale 1ns/1ps
`default_nettype none

module tb_branch_predictor;
    import bp_pkg::*;

    localparam int WAIT_LIMIT = 50;
    localparam addr_t RET_PC  = 32'h0000_3f80;

    typedef struct packed {
        addr_t    pc;
        addr_t    npc;
        logic     taken;
        logic     hit;
        br_kind_e kind;
    } pred_t;

    logic     clk, rstn;
    logic     pc_valid, pc_ready, pred_valid, pred_taken, pred_hit, pred_ready;
    logic     upd_valid, upd_taken;
    addr_t    pc, pred_pc, pred_npc, upd_pc, upd_target;
    br_kind_e pred_kind, upd_kind;

    // reference model state
    ctr_t     m_pht [PHT_SIZE];
    ghist_t   m_ghist;
    logic     m_bv [BTB_SIZE];
    btb_tag_t m_btag [BTB_SIZE];
    br_kind_e m_bkind [BTB_SIZE];
    addr_t    m_btgt [BTB_SIZE];
    addr_t    m_ras [RAS_DEPTH];
    int       m_sp, m_cnt;

    pred_t    exp_q [$];
    pred_t    exp_head;
    logic     exp_valid;
    int       fail_cnt = 0;
    int       checked = 0;
    int       tests_passed = 0;
    int       tests_failed = 0;
    integer   seed = 32'h5646;

    branch_predictor DUT (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic void model_reset();
        for (int i = 0; i < PHT_SIZE; i++) begin
            m_pht[i] = 2'd1;  // weakly not-taken
        end
        for (int i = 0; i < BTB_SIZE; i++) begin
            m_bv[i] = 1'b0;
        end
        m_ghist = '0;
        m_sp    = 0;
        m_cnt   = 0;
    endfunction

    function automatic pred_t predict(input addr_t a);
        pred_t  p;
        ghist_t gi;
        gi      = a[9:2] ^ m_ghist;
        p.pc    = a;
        p.npc   = a + 32'd4;
        p.taken = 1'b0;
        p.hit   = m_bv[a[7:2]] && (m_btag[a[7:2]] == a[31:8]);
        p.kind  = p.hit ? m_bkind[a[7:2]] : KIND_BRANCH;
        if (p.hit) begin
            case (p.kind)
                KIND_JUMP, KIND_CALL: begin
                    p.taken = 1'b1;
                    p.npc   = m_btgt[a[7:2]];
                end
                KIND_RET: begin
                    if (m_cnt > 0) begin
                        p.taken = 1'b1;
                        p.npc   = m_ras[(m_sp + RAS_DEPTH - 1) % RAS_DEPTH];
                    end
                end
                default: begin
                    if (m_pht[gi][1]) begin
                        p.taken = 1'b1;
                        p.npc   = m_btgt[a[7:2]];
                    end
                end
            endcase
        end
        return p;
    endfunction

    function automatic void apply_update(input addr_t a, input br_kind_e k, input logic t,
                                         input addr_t tgt);
        ghist_t gi;
        gi = a[9:2] ^ m_ghist;
        if (k == KIND_BRANCH) begin
            if (t && m_pht[gi] != 2'd3) begin
                m_pht[gi] = m_pht[gi] + 2'd1;
            end else if (!t && m_pht[gi] != 2'd0) begin
                m_pht[gi] = m_pht[gi] - 2'd1;
            end
            m_ghist = {m_ghist[6:0], t};
        end
        if (t || k != KIND_BRANCH) begin
            m_bv[a[7:2]]    = 1'b1;
            m_btag[a[7:2]]  = a[31:8];
            m_bkind[a[7:2]] = k;
            m_btgt[a[7:2]]  = tgt;
        end
        if (k == KIND_CALL) begin
            m_ras[m_sp] = a + 32'd4;
            m_sp = (m_sp + 1) % RAS_DEPTH;  // oldest overwritten when full
            if (m_cnt < RAS_DEPTH) begin
                m_cnt++;
            end
        end else if (k == KIND_RET && m_cnt > 0) begin
            m_sp = (m_sp + RAS_DEPTH - 1) % RAS_DEPTH;
            m_cnt--;
        end
    endfunction

    // lookup sees the state from before a same-cycle update
    always @(posedge clk) begin
        if (!rstn) begin
            model_reset();
            exp_q.delete();
            exp_valid <= 1'b0;
        end else begin
            if (pred_valid && pred_ready && exp_q.size() > 0) begin
                void'(exp_q.pop_front());
                checked++;
            end
            if (pc_valid && pc_ready) begin
                exp_q.push_back(predict(pc));
            end
            if (upd_valid) begin
                apply_update(upd_pc, upd_kind, upd_taken, upd_target);
            end
            exp_valid <= (exp_q.size() > 0);
            if (exp_q.size() > 0) begin
                exp_head <= exp_q[0];
            end
        end
    end

    a_pred_match : assert property (@(posedge clk) disable iff (!rstn)
        (pred_valid && pred_ready) |-> (exp_valid && pred_pc == exp_head.pc &&
            pred_npc == exp_head.npc && pred_taken == exp_head.taken &&
            pred_hit == exp_head.hit && (!exp_head.hit || pred_kind == exp_head.kind)))
    else begin
        $display("FAIL %0t: pc %h got npc %h taken %b hit %b, want npc %h taken %b hit %b",
                 $time, $sampled(pred_pc), $sampled(pred_npc), $sampled(pred_taken),
                 $sampled(pred_hit), $sampled(exp_head.npc), $sampled(exp_head.taken),
                 $sampled(exp_head.hit));
        fail_cnt++;
    end

    a_one_cycle : assert property (@(posedge clk) disable iff (!rstn)
        (pc_valid && pc_ready) |=> pred_valid)
    else begin
        $display("FAIL %0t: no prediction one cycle after an accepted lookup", $time);
        fail_cnt++;
    end

    a_stall_hold : assert property (@(posedge clk) disable iff (!rstn)
        (pred_valid && !pred_ready) |=> (pred_valid && $stable(pred_pc) && $stable(pred_npc)
            && $stable(pred_taken) && $stable(pred_hit) && $stable(pred_kind)))
    else begin
        $display("FAIL %0t: prediction outputs moved while stalled", $time);
        fail_cnt++;
    end

    a_stall_ready : assert property (@(posedge clk) disable iff (!rstn)
        (pred_valid && !pred_ready) |-> !pc_ready)
    else begin
        $display("FAIL %0t: pc_ready high while the prediction is stalled", $time);
        fail_cnt++;
    end

    a_no_x : assert property (@(posedge clk) disable iff (!rstn)
        pred_valid |-> !$isunknown({pred_pc, pred_npc, pred_taken, pred_hit, pred_kind}))
    else begin
        $display("FAIL %0t: unknown value on a valid prediction", $time);
        fail_cnt++;
    end

    task automatic wait_accept();
        int n;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!pc_ready && n < WAIT_LIMIT);
        if (!pc_ready) begin
            $display("timeout: a lookup request was never accepted");
            $display("TESTBENCH FAILED");
            $finish;
        end else begin
            pc_valid <= 1'b0;
        end
    endtask

    task automatic do_lookup(input addr_t a);
        pc_valid <= 1'b1;
        pc       <= a;
        wait_accept();
    endtask

    // returns once the last prediction has been taken
    task automatic wait_idle();
        int n;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (pred_valid && n < WAIT_LIMIT);
        if (pred_valid) begin
            $display("timeout: a prediction was never consumed");
            $display("TESTBENCH FAILED");
            $finish;
        end
    endtask

    task automatic lookup_and_wait(input addr_t a);
        do_lookup(a);
        wait_idle();
    endtask

    task automatic send_update(input addr_t a, input br_kind_e k, input logic t,
                               input addr_t tgt);
        upd_valid  <= 1'b1;
        upd_pc     <= a;
        upd_kind   <= k;
        upd_taken  <= t;
        upd_target <= tgt;
        @(posedge clk);
        upd_valid <= 1'b0;
    endtask

    task automatic end_test(input string name, input int errs_at_start);
        if (fail_cnt == errs_at_start) begin
            tests_passed++;
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, fail_cnt - errs_at_start);
        end
    endtask

    initial begin
        int  mark;
        int  r, r2, r3;
        time t0;
        rstn       = 1'b0;
        pc_valid   = 1'b0;
        pc         = '0;
        pred_ready = 1'b1;
        upd_valid  = 1'b0;
        upd_pc     = '0;
        upd_kind   = KIND_BRANCH;
        upd_taken  = 1'b0;
        upd_target = '0;
        repeat (2) @(posedge clk);
        rstn <= 1'b1;
        @(posedge clk);

        mark = fail_cnt;
        assert (!pred_valid) else begin
            $display("FAIL %0t: pred_valid high after reset", $time);
            fail_cnt++;
        end
        lookup_and_wait(32'h0000_0100);
        lookup_and_wait(32'h0000_0104);
        lookup_and_wait(32'h0000_0200);
        end_test("cold state", mark);

        mark = fail_cnt;
        for (int i = 0; i < 10; i++) begin
            send_update(32'h0000_2040, KIND_BRANCH, 1'b1, 32'h0000_2400);
            if (i % 3 == 0) begin
                lookup_and_wait(32'h0000_2040);
            end
        end
        lookup_and_wait(32'h0000_2040);  // saturated on the all-ones history
        for (int i = 0; i < 10; i++) begin
            send_update(32'h0000_2040, KIND_BRANCH, 1'b0, 32'h0000_2400);
            if (i % 3 == 0) begin
                lookup_and_wait(32'h0000_2040);
            end
        end
        end_test("branch training", mark);

        mark = fail_cnt;
        send_update(32'h0000_2100, KIND_JUMP, 1'b1, 32'h0000_2800);
        send_update(32'h0000_2204, KIND_CALL, 1'b1, 32'h0000_2900);
        lookup_and_wait(32'h0000_2100);
        lookup_and_wait(32'h0000_2204);
        end_test("jump and call", mark);

        mark = fail_cnt;
        send_update(RET_PC, KIND_RET, 1'b1, 32'h0);
        send_update(RET_PC, KIND_RET, 1'b1, 32'h0);
        lookup_and_wait(RET_PC);  // empty stack
        for (int i = 0; i < 3; i++) begin
            send_update(32'h0000_3004 + i * 32'h10, KIND_CALL, 1'b1, 32'h0000_3800);
        end
        for (int i = 0; i < 4; i++) begin
            lookup_and_wait(RET_PC);
            send_update(RET_PC, KIND_RET, 1'b1, 32'h0);
        end
        for (int i = 0; i < 9; i++) begin
            send_update(32'h0000_3400 + i * 4, KIND_CALL, 1'b1, 32'h0000_3c00);
        end
        for (int i = 0; i < 9; i++) begin
            lookup_and_wait(RET_PC);
            send_update(RET_PC, KIND_RET, 1'b1, 32'h0);
        end
        end_test("return stack", mark);

        mark = fail_cnt;
        pred_ready <= 1'b0;
        do_lookup(32'h0000_2100);
        pc_valid <= 1'b1;
        pc       <= 32'h0000_2204;
        repeat (6) @(posedge clk);
        pred_ready <= 1'b1;
        wait_accept();
        t0 = $time;
        for (int i = 0; i < 8; i++) begin
            do_lookup(32'h0000_6000 + i * 4);
        end
        if ($time - t0 != 80) begin
            $display("FAIL %0t: back-to-back lookups took %0t ns for 8", $time, $time - t0);
            fail_cnt++;
        end
        wait_idle();
        end_test("back-pressure", mark);

        mark = fail_cnt;
        for (int c = 0; c < 2000; c++) begin
            r  = $random(seed);
            r2 = $random(seed);
            r3 = $random(seed);
            if (!pc_valid || pc_ready) begin
                pc_valid <= r[0] | r[1];
                pc       <= 32'h0000_1000 + {20'd0, r2[9:0], 2'b00};
            end
            pred_ready <= r[2] | r[3];
            upd_valid  <= r[4];
            upd_taken  <= r[5];
            upd_kind   <= br_kind_e'(r[7:6]);
            upd_pc     <= 32'h0000_1000 + {20'd0, r2[19:10], 2'b00};
            upd_target <= {r3[31:2], 2'b00};
            @(posedge clk);
        end
        pc_valid   <= 1'b0;
        upd_valid  <= 1'b0;
        pred_ready <= 1'b1;
        wait_idle();
        end_test("random stream", mark);

        if (exp_valid) begin
            $display("an expected prediction was never delivered");
            fail_cnt++;
        end
        $display("tests passed %0d, failed %0d, predictions checked %0d, errors %0d",
                 tests_passed, tests_failed, checked, fail_cnt);
        if (fail_cnt == 0 && tests_failed == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
source/bp_pkg.sv
source/direction_predictor.sv
source/target_predictor.sv
source/next_pc_select.sv
source/branch_predictor.sv
tb/tb_branch_predictor.sv

//--- Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := tb_branch_predictor
FILELIST := build.f
OBJDIR   := obj_dir
PASS_MSG := TESTBENCH PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR) -o $(TOP)
	@out="$$(./$(OBJDIR)/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)
